/* logic/fxp_pkg.sv */
// fixed-point converter definitions
`default_nettype none

package fxp_pkg;

   ////////////////////////////////////////////////////////////
   // formats
   ////////////////////////////////////////////////////////////

   localparam int IN_W     = 16;                  // signed Q8.8 sample
   localparam int IN_FRAC  = 8;
   localparam int OUT_W    = 8;                   // signed Q4.4 result
   localparam int OUT_FRAC = 4;
   localparam int DROP_LSB = IN_FRAC - OUT_FRAC;  // fraction bits removed
   localparam int Q_W      = IN_W - DROP_LSB + 1; // one guard bit for the round carry

   localparam int N_LANES = 2;  // samples per bus word
   localparam int WB_DW   = 32;
   localparam int WB_AW   = 4;

   ////////////////////////////////////////////////////////////
   // vector types
   ////////////////////////////////////////////////////////////

   typedef logic signed [IN_W-1:0]  in_sample_t;
   typedef logic signed [OUT_W-1:0] out_sample_t;
   typedef logic signed [Q_W-1:0]   quant_t;
   typedef logic [WB_DW-1:0]        wb_data_t;
   typedef logic [WB_AW-1:0]        wb_addr_t;

   // saturation limits of the output format
   localparam out_sample_t OUT_MAX = {1'b0, {(OUT_W-1){1'b1}}};
   localparam out_sample_t OUT_MIN = {1'b1, {(OUT_W-1){1'b0}}};

   // register map, word offsets
   localparam wb_addr_t ADDR_CTRL    = 4'd0;  // mode, read/write
   localparam wb_addr_t ADDR_DATA_IN = 4'd1;  // write starts a conversion
   localparam wb_addr_t ADDR_RESULT  = 4'd2;  // read only
   localparam wb_addr_t ADDR_STATUS  = 4'd3;  // write clears sticky flags

   ////////////////////////////////////////////////////////////
   // modes and structs
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      Q_TRUNC      = 2'd0,  // toward minus infinity
      Q_ROUND_INF  = 2'd1,  // ties away from zero
      Q_ROUND_EVEN = 2'd2   // ties to even
   } quant_mode_e;

   typedef enum logic {
      O_WRAP     = 1'b0,
      O_SATURATE = 1'b1
   } ovf_mode_e;

   typedef struct packed {
      quant_mode_e quant;  // CTRL bits 2:1
      ovf_mode_e   ovf;    // CTRL bit 0
   } conv_mode_t;

   typedef struct packed {
      logic       valid;
      in_sample_t sample;
   } lane_in_t;

   typedef struct packed {
      logic        valid;
      out_sample_t sample;
      logic        sat;  // clamped by saturation
   } lane_out_t;

   typedef struct packed {
      logic [N_LANES-1:0]        sat;     // sticky per lane
      logic                      done;
      out_sample_t [N_LANES-1:0] sample;  // lane 0 in the low byte
   } result_t;

endpackage

`default_nettype wire

/* logic/fxp_wb_regs.sv */
// wishbone register slave
`timescale 1ns/1ps
`default_nettype none

module fxp_wb_regs
   import fxp_pkg::*;
(
   input  wire                         clk,
   input  wire                         reset,
   input  wire                         cyc,
   input  wire                         stb,
   input  wire                         we,
   input  wire wb_addr_t               adr,
   input  wire wb_data_t               dat_w,
   input  wire result_t                result,
   output wb_data_t                    dat_r,
   output logic                        ack,
   output conv_mode_t                  mode,
   output lane_in_t [N_LANES-1:0]      lane_in,
   output logic                        clear_done,
   output logic                        clear_sat
);

   logic                     req;
   logic                     wr_req;
   logic                     rd_req;
   logic                     issue_q;   // one-clock lane valid
   in_sample_t [N_LANES-1:0] sample_q;
   wb_data_t                 rd_data;

   // ack low masks the held request so each cycle is acked once
   assign req    = cyc & stb & ~ack;
   assign wr_req = req & we;
   assign rd_req = req & ~we;

   ////////////////////////////////////////////////////////////
   // control registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack        <= 1'b0;
         mode       <= '{quant: Q_TRUNC, ovf: O_WRAP};
         issue_q    <= 1'b0;
         clear_done <= 1'b0;
         clear_sat  <= 1'b0;
      end
      else
      begin
         ack        <= req;
         issue_q    <= wr_req && (adr == ADDR_DATA_IN);  // lines up with ack
         clear_done <= wr_req && (adr == ADDR_DATA_IN);
         clear_sat  <= wr_req && (adr == ADDR_STATUS);
         if (wr_req && (adr == ADDR_CTRL))
         begin
            mode <= conv_mode_t'(dat_w[$bits(conv_mode_t)-1:0]);
         end
      end
   end

   // sample 0 from bits 15:0, sample 1 from bits 31:16
   always_ff @(posedge clk)
   begin
      if (wr_req && (adr == ADDR_DATA_IN))
      begin
         sample_q <= dat_w;
      end
   end

   always_comb
   begin
      for (int i = 0; i < N_LANES; i++)
      begin
         lane_in[i].valid  = issue_q;
         lane_in[i].sample = sample_q[i];
      end
   end

   ////////////////////////////////////////////////////////////
   // read path
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (adr)
         ADDR_CTRL:   rd_data = WB_DW'(mode);
         ADDR_RESULT: rd_data = WB_DW'({result.done, result.sample});
         ADDR_STATUS: rd_data = WB_DW'(result.sat);
         default:     rd_data = '0;  // DATA_IN reads as zero
      endcase
   end

   // captured at the request, presented while ack is high
   always_ff @(posedge clk)
   begin
      if (rd_req)
      begin
         dat_r <= rd_data;
      end
   end

endmodule

`default_nettype wire

/* logic/fxp_lane.sv */
// Q8.8 to Q4.4 conversion lane
`timescale 1ns/1ps
`default_nettype none

module fxp_lane
   import fxp_pkg::*;
(
   input  wire             clk,
   input  wire             reset,
   input  wire conv_mode_t mode,
   input  wire lane_in_t   lane_in,
   output lane_out_t       lane_out
);

   // stage one, quantization
   in_sample_t  smp;
   quant_t      q_trunc;     // kept bits, sign extended by one
   logic        half_bit;    // first discarded bit
   logic        low_bits;    // any discarded bit below the half bit
   logic        kept_lsb;
   logic        round_inc;
   quant_t      q_round;

   logic        s1_valid;
   quant_t      s1_q;
   ovf_mode_e   s1_ovf;      // overflow mode travels with the item

   // stage two, overflow
   logic        in_range;
   out_sample_t ovf_sample;
   logic        ovf_sat;

   logic        s2_valid;
   out_sample_t s2_sample;
   logic        s2_sat;

   ////////////////////////////////////////////////////////////
   // stage one
   ////////////////////////////////////////////////////////////

   assign smp      = lane_in.sample;
   assign q_trunc  = {smp[IN_W-1], smp[IN_W-1:DROP_LSB]};
   assign half_bit = smp[DROP_LSB-1];
   assign low_bits = |smp[DROP_LSB-2:0];
   assign kept_lsb = smp[DROP_LSB];

   always_comb
   begin
      case (mode.quant)
         Q_ROUND_INF:
            // positive ties go up, negative ties stay on the floor
            round_inc = half_bit & (~smp[IN_W-1] | low_bits);
         Q_ROUND_EVEN:
            round_inc = half_bit & (low_bits | kept_lsb);  // exact tie takes the lsb
         default:
            round_inc = 1'b0;  // truncate
      endcase
   end

   // guard bit keeps 0x7FF + 1 from wrapping
   assign q_round = q_trunc + quant_t'(round_inc);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         s1_valid <= 1'b0;
      end
      else
      begin
         s1_valid <= lane_in.valid;
      end
   end

   always_ff @(posedge clk)
   begin
      s1_q   <= q_round;
      s1_ovf <= mode.ovf;
   end

   ////////////////////////////////////////////////////////////
   // stage two
   ////////////////////////////////////////////////////////////

   // fits when all bits down to the output sign agree
   assign in_range = (&s1_q[Q_W-1:OUT_W-1]) | ~(|s1_q[Q_W-1:OUT_W-1]);

   always_comb
   begin
      ovf_sample = s1_q[OUT_W-1:0];  // wrap keeps the low byte
      ovf_sat    = 1'b0;
      if ((s1_ovf == O_SATURATE) && !in_range)
      begin
         ovf_sample = s1_q[Q_W-1] ? OUT_MIN : OUT_MAX;
         ovf_sat    = 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         s2_valid <= 1'b0;
      end
      else
      begin
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      s2_sample <= ovf_sample;
      s2_sat    <= ovf_sat;
   end

   assign lane_out = '{valid: s2_valid, sample: s2_sample, sat: s2_sat};

endmodule

`default_nettype wire

/* logic/fxp_result_collect.sv */
// lane result collector
`timescale 1ns/1ps
`default_nettype none

module fxp_result_collect
   import fxp_pkg::*;
(
   input  wire                         clk,
   input  wire                         reset,
   input  wire                         clear_done,
   input  wire                         clear_sat,
   input  wire lane_out_t [N_LANES-1:0] lane_out,
   output result_t                     result
);

   logic [N_LANES-1:0]        lane_valid;
   logic [N_LANES-1:0]        lane_sat;    // saturation seen this clock
   logic                      done_q;
   logic [N_LANES-1:0]        sat_q;
   out_sample_t [N_LANES-1:0] sample_q;

   always_comb
   begin
      for (int i = 0; i < N_LANES; i++)
      begin
         lane_valid[i] = lane_out[i].valid;
         lane_sat[i]   = lane_out[i].valid & lane_out[i].sat;
      end
   end

   ////////////////////////////////////////////////////////////
   // done and sticky flags
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         done_q <= 1'b0;
         sat_q  <= '0;
      end
      else
      begin
         // a new write outranks an older result arriving now
         if (clear_done)
         begin
            done_q <= 1'b0;
         end
         else if (&lane_valid)
         begin
            done_q <= 1'b1;
         end
         sat_q <= (clear_sat ? '0 : sat_q) | lane_sat;  // never drop a fresh hit
      end
   end

   // latest result overwrites
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < N_LANES; i++)
      begin
         if (lane_valid[i])
         begin
            sample_q[i] <= lane_out[i].sample;
         end
      end
   end

   assign result = '{sat: sat_q, done: done_q, sample: sample_q};

endmodule

`default_nettype wire

/* logic/fxp_convert_top.sv */
// fixed-point converter top
`timescale 1ns/1ps
`default_nettype none

module fxp_convert_top
   import fxp_pkg::*;
(
   input  wire           clk,
   input  wire           reset,
   input  wire           cyc,
   input  wire           stb,
   input  wire           we,
   input  wire wb_addr_t adr,
   input  wire wb_data_t dat_w,
   output wire wb_data_t dat_r,
   output wire           ack
);

   conv_mode_t               mode;
   lane_in_t  [N_LANES-1:0]  lane_in;
   lane_out_t [N_LANES-1:0]  lane_out;
   logic                     clear_done;
   logic                     clear_sat;
   result_t                  result;

   fxp_wb_regs fxp_wb_regs_i (
      .clk        (clk),
      .reset      (reset),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .dat_w      (dat_w),
      .result     (result),
      .dat_r      (dat_r),
      .ack        (ack),
      .mode       (mode),
      .lane_in    (lane_in),
      .clear_done (clear_done),
      .clear_sat  (clear_sat)
   );

   // one lane per 16-bit half of the bus word
   for (genvar i = 0; i < N_LANES; i++)
   begin : g_lane
      fxp_lane fxp_lane_i (
         .clk      (clk),
         .reset    (reset),
         .mode     (mode),
         .lane_in  (lane_in[i]),
         .lane_out (lane_out[i])
      );
   end

   fxp_result_collect fxp_result_collect_i (
      .clk        (clk),
      .reset      (reset),
      .clear_done (clear_done),
      .clear_sat  (clear_sat),
      .lane_out   (lane_out),
      .result     (result)
   );

endmodule

`default_nettype wire

/* verification/fxp_tb_checks.svh */
// testbench compare tasks
`ifndef FXP_TB_CHECKS_SVH
`define FXP_TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// run abort
////////////////////////////////////////////////////////////

task automatic abort_run();
   $display("TB FAILED");
   $fatal(1, "simulation stopped");
endtask

////////////////////////////////////////////////////////////
// typed compares
////////////////////////////////////////////////////////////

// CTRL readback against the written mode
task automatic check_mode(input conv_mode_t got, input conv_mode_t exp, input int idx);
   if (got !== exp)
   begin
      $display("Error at %0d ns: vector %0d CTRL read back %b, expected %b",
               $time, idx, got, exp);
      error_count++;
      abort_run();
   end
endtask

// only done and the lane samples are visible in RESULT
// samples are compared only when done is expected
task automatic check_result(input result_t got, input result_t exp, input int idx);
   if ((got.done !== exp.done) || (exp.done && (got.sample !== exp.sample)))
   begin
      $display("Error at %0d ns: vector %0d RESULT done %b samples %h, expected done %b samples %h",
               $time, idx, got.done, got.sample, exp.done, exp.sample);
      error_count++;
      abort_run();
   end
endtask

task automatic check_status(input logic [N_LANES-1:0] got, input logic [N_LANES-1:0] exp,
                            input int idx);
   if (got !== exp)
   begin
      $display("Error at %0d ns: vector %0d STATUS flags %b, expected %b",
               $time, idx, got, exp);
      error_count++;
      abort_run();
   end
endtask

`endif

/* verification/fxp_convert_tb.sv */
// fixed-point converter testbench
`timescale 1ns/1ps
`default_nettype none

module fxp_convert_tb
   import fxp_pkg::*;
();

   localparam int ACK_LIMIT = 8;              // clocks to wait for ack
   localparam int MAX_POLLS = 10;             // RESULT reads before giving up
   localparam int DONE_BIT  = OUT_W * N_LANES;

   logic     clk;
   logic     reset;
   logic     cyc;
   logic     stb;
   logic     we;
   wb_addr_t adr;
   wb_data_t dat_w;
   wb_data_t dat_r;
   logic     ack;

   // one entry per stimulus line
   conv_mode_t                vec_mode[$];
   wb_data_t                  vec_in[$];
   out_sample_t [N_LANES-1:0] vec_result[$];
   logic [N_LANES-1:0]        vec_sat[$];

   int cycle_count = 0;
   int cycle_limit = 0;  // set once the vectors are loaded
   int error_count = 0;

   `include "fxp_tb_checks.svh"

   fxp_convert_top fxp_convert_top_i (
      .clk   (clk),
      .reset (reset),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #50 clk = ~clk;
      end
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if ((cycle_limit > 0) && (cycle_count >= cycle_limit))
      begin
         $display("Timeout: the run went past its limit of %0d clock cycles", cycle_limit);
         abort_run();
      end
   end

   ////////////////////////////////////////////////////////////
   // wishbone master
   ////////////////////////////////////////////////////////////

   // ack is looked at on the falling edge, away from the DUT updates
   task automatic wait_ack();
      int waited;
      waited = 0;
      do
      begin
         @(negedge clk);
         waited++;
      end while (!ack && (waited < ACK_LIMIT));
      if (!ack)
      begin
         $display("Bus failure: no ack within %0d clocks of a request", ACK_LIMIT);
         abort_run();
      end
   endtask

   task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
      @(posedge clk);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= 1'b1;
      adr   <= addr;
      dat_w <= data;
      wait_ack();
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
   endtask

   task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we  <= 1'b0;
      adr <= addr;
      wait_ack();
      data = dat_r;  // valid while ack is high
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // vectors
   ////////////////////////////////////////////////////////////

   task automatic load_vectors();
      int          fd;
      int          fields;
      string       line;
      logic [31:0] f_mode;
      logic [31:0] f_in;
      logic [31:0] f_result;
      logic [31:0] f_sat;
      fd = $fopen("verification/fxp_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file verification/fxp_stimulus.txt");
         abort_run();
      end
      while ($fgets(line, fd) > 0)
      begin
         if ((line.len() > 1) && (line.getc(0) != "#"))
         begin
            fields = $sscanf(line, "%h %h %h %h", f_mode, f_in, f_result, f_sat);
            if (fields == 4)
            begin
               vec_mode.push_back(conv_mode_t'(f_mode[$bits(conv_mode_t)-1:0]));
               vec_in.push_back(f_in);
               vec_result.push_back(f_result[DONE_BIT-1:0]);
               vec_sat.push_back(f_sat[N_LANES-1:0]);
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic run_vector(input int idx);
      wb_data_t rd;
      result_t  got;
      result_t  exp;
      int       polls;
      wb_write(ADDR_CTRL, WB_DW'(vec_mode[idx]));
      wb_read(ADDR_CTRL, rd);
      check_mode(conv_mode_t'(rd[$bits(conv_mode_t)-1:0]), vec_mode[idx], idx);
      wb_write(ADDR_STATUS, '0);  // clear sticky flags
      wb_write(ADDR_DATA_IN, vec_in[idx]);
      got.sat    = '0;
      exp.sat    = '0;
      exp.sample = vec_result[idx];
      polls = 0;
      do
      begin
         wb_read(ADDR_RESULT, rd);
         got.done   = rd[DONE_BIT];
         got.sample = rd[DONE_BIT-1:0];
         // the write cleared done and the lanes need three clocks to set it again
         if (polls == 0)
         begin
            exp.done = 1'b0;
            check_result(got, exp, idx);
         end
         polls++;
      end while (!got.done && (polls < MAX_POLLS));
      if (!got.done)
      begin
         $display("Vector %0d: RESULT never showed done after %0d reads", idx, MAX_POLLS);
         abort_run();
      end
      exp.done = 1'b1;
      check_result(got, exp, idx);
      wb_read(ADDR_STATUS, rd);
      check_status(rd[N_LANES-1:0], vec_sat[idx], idx);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      reset <= 1'b1;
      cyc   <= 1'b0;
      stb   <= 1'b0;
      we    <= 1'b0;
      adr   <= '0;
      dat_w <= '0;
      load_vectors();
      if (vec_in.size() == 0)
      begin
         $display("The stimulus file holds no test vectors");
         abort_run();
      end
      cycle_limit = vec_in.size() * 40 + 200;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < vec_in.size(); i++)
      begin
         run_vector(i);
      end
      if (error_count == 0)
      begin
         $display("TB PASSED");
         $finish;
      end
      else
      begin
         abort_run();
      end
   end

endmodule

`default_nettype wire

/* verification/fxp_stimulus.txt */
# columns: CTRL mode (quant<<1 | ovf), DATA_IN word, expected RESULT[15:0], expected STATUS
# samples are signed Q8.8 with lane 0 in bits 15:0, results signed Q4.4 with lane 0 low
0 fff00107 ff10 0
0 fff80058 ff05 0
0 e5a71234 5a23 0
2 fff80008 ff01 0
2 00190017 0201 0
2 ffe9ffe7 fffe 0
2 ffe80028 fe03 0
4 00480018 0402 0
4 ffd8ffe8 fefe 0
4 00270019 0202 0
4 fff70014 ff01 0
1 01071234 107f 1
0 01071234 1023 0
1 e5a7fff0 80ff 2
0 e5a7fff0 5aff 0
3 07f707ff 7f7f 1
2 07f707ff 7f80 0
1 f800f7ff 8080 1
5 80007fff 807f 3
4 80007fff 0000 0

/* vlog.f */
+incdir+verification
logic/fxp_pkg.sv
logic/fxp_wb_regs.sv
logic/fxp_lane.sv
logic/fxp_result_collect.sv
logic/fxp_convert_top.sv
verification/fxp_convert_tb.sv

/* Makefile */
# Verilator build and run for the fixed-point converter

VERILATOR ?= verilator
TOP       ?= fxp_convert_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard logic/*.sv verification/*.sv verification/*.svh)
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the verdict comes from the log, not from the simulator exit code
run: $(SIM_EXE)
	./$(SIM_EXE) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
